// File: periph_link_pkg.sv
`default_nettype none

package periph_link_pkg;

  //////////////////////////////////////////////////
  // Widths and address map
  //////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = 4;

  // UART occupies one 4 KiB window
  localparam logic [ADDR_W-1:0] UART_BASE = 32'h0000_2000;
  localparam logic [ADDR_W-1:0] UART_MASK = 32'hFFFF_F000;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_ADDR,
    ST_WR_RESP,
    ST_RD_ADDR,
    ST_RD_DATA,
    ST_DONE
  } bridge_state_e;

  // Word offsets inside the UART window
  typedef enum logic [3:0] {
    REG_TXDATA  = 4'h0,
    REG_RXDATA  = 4'h4,
    REG_STATUS  = 4'h8,
    REG_BAUDDIV = 4'hC
  } uart_reg_e;

  //////////////////////////////////////////////////
  // Bus structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [STRB_W-1:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    logic              pready;
    logic [DATA_W-1:0] prdata;
    logic              pslverr;
  } apb_resp_t;

  typedef struct packed {
    logic              aw_valid;
    logic [ADDR_W-1:0] aw_addr;
    logic              w_valid;
    logic [DATA_W-1:0] w_data;
    logic [STRB_W-1:0] w_strb;
    logic              b_ready;
    logic              ar_valid;
    logic [ADDR_W-1:0] ar_addr;
    logic              r_ready;
  } axil_req_t;

  typedef struct packed {
    logic              aw_ready;
    logic              w_ready;
    logic              b_valid;
    axil_resp_e        b_resp;
    logic              ar_ready;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
    axil_resp_e        r_resp;
  } axil_resp_t;

endpackage

`default_nettype wire

// File: apb_to_axil.sv
`timescale 1ns/1ps
`default_nettype none

module apb_to_axil (
  input  logic                        periphl_clk_i,
  input  logic                        rst_n_i,
  input  periph_link_pkg::apb_req_t   apb_req_i,
  output periph_link_pkg::apb_resp_t  apb_resp_o,
  output periph_link_pkg::axil_req_t  axil_req_o,
  input  periph_link_pkg::axil_resp_t axil_resp_i
);

  periph_link_pkg::bridge_state_e state_q, state_d;

  logic                                aw_done_q;
  logic                                w_done_q;
  logic                                aw_hs;
  logic                                w_hs;
  logic                                err_q;
  logic [periph_link_pkg::DATA_W-1:0] rdata_q;

  // APB holds the request until pready, so address and data come straight through
  always_comb begin
    axil_req_o          = '0;
    axil_req_o.aw_addr  = apb_req_i.paddr;
    axil_req_o.ar_addr  = apb_req_i.paddr;
    axil_req_o.w_data   = apb_req_i.pwdata;
    axil_req_o.w_strb   = apb_req_i.pstrb;
    axil_req_o.aw_valid = (state_q == periph_link_pkg::ST_WR_ADDR) && !aw_done_q;
    axil_req_o.w_valid  = (state_q == periph_link_pkg::ST_WR_ADDR) && !w_done_q;
    axil_req_o.b_ready  = (state_q == periph_link_pkg::ST_WR_RESP);
    axil_req_o.ar_valid = (state_q == periph_link_pkg::ST_RD_ADDR);
    axil_req_o.r_ready  = (state_q == periph_link_pkg::ST_RD_DATA);
  end

  assign aw_hs = axil_req_o.aw_valid && axil_resp_i.aw_ready;
  assign w_hs  = axil_req_o.w_valid && axil_resp_i.w_ready;

  //////////////////////////////////////////////////
  // Transfer FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      periph_link_pkg::ST_IDLE: begin
        if (apb_req_i.psel && apb_req_i.penable) begin
          state_d = apb_req_i.pwrite ? periph_link_pkg::ST_WR_ADDR
                                     : periph_link_pkg::ST_RD_ADDR;
        end
      end
      periph_link_pkg::ST_WR_ADDR: begin
        // Address and data may be taken in different cycles
        if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
          state_d = periph_link_pkg::ST_WR_RESP;
        end
      end
      periph_link_pkg::ST_WR_RESP: begin
        if (axil_resp_i.b_valid) begin
          state_d = periph_link_pkg::ST_DONE;
        end
      end
      periph_link_pkg::ST_RD_ADDR: begin
        if (axil_resp_i.ar_ready) begin
          state_d = periph_link_pkg::ST_RD_DATA;
        end
      end
      periph_link_pkg::ST_RD_DATA: begin
        if (axil_resp_i.r_valid) begin
          state_d = periph_link_pkg::ST_DONE;
        end
      end
      default: state_d = periph_link_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge periphl_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= periph_link_pkg::ST_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d != periph_link_pkg::ST_WR_ADDR) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end else begin
        aw_done_q <= aw_done_q | aw_hs;
        w_done_q  <= w_done_q | w_hs;
      end
      if (axil_req_o.b_ready && axil_resp_i.b_valid) begin
        err_q <= (axil_resp_i.b_resp == periph_link_pkg::RESP_SLVERR);
      end
      if (axil_req_o.r_ready && axil_resp_i.r_valid) begin
        err_q <= (axil_resp_i.r_resp == periph_link_pkg::RESP_SLVERR);
      end
    end
  end

  // Read data capture
  always_ff @(posedge periphl_clk_i) begin
    if (axil_req_o.r_ready && axil_resp_i.r_valid) begin
      rdata_q <= axil_resp_i.r_data;
    end
  end

  assign apb_resp_o.pready  = (state_q == periph_link_pkg::ST_DONE);
  assign apb_resp_o.prdata  = rdata_q;
  assign apb_resp_o.pslverr = err_q;

endmodule

`default_nettype wire

// File: periph_link_decode.sv
`timescale 1ns/1ps
`default_nettype none

module periph_link_decode (
  input  logic                        periphl_clk_i,
  input  logic                        rst_n_i,
  input  periph_link_pkg::axil_req_t  mst_req_i,
  output periph_link_pkg::axil_resp_t mst_resp_o,
  output periph_link_pkg::axil_req_t  uart_req_o,
  input  periph_link_pkg::axil_resp_t uart_resp_i
);

  logic aw_hit;
  logic ar_hit;
  logic wr_pend_q;
  logic rd_pend_q;

  // Write data follows the write address window
  assign aw_hit = (mst_req_i.aw_addr & periph_link_pkg::UART_MASK) == periph_link_pkg::UART_BASE;
  assign ar_hit = (mst_req_i.ar_addr & periph_link_pkg::UART_MASK) == periph_link_pkg::UART_BASE;

  always_comb begin
    uart_req_o          = mst_req_i;
    uart_req_o.aw_valid = mst_req_i.aw_valid && aw_hit;
    uart_req_o.w_valid  = mst_req_i.w_valid && aw_hit;
    uart_req_o.ar_valid = mst_req_i.ar_valid && ar_hit;
    uart_req_o.b_ready  = mst_req_i.b_ready && !wr_pend_q;
    uart_req_o.r_ready  = mst_req_i.r_ready && !rd_pend_q;

    mst_resp_o = uart_resp_i;
    // Error responder takes address and data in one beat
    if (!aw_hit) begin
      mst_resp_o.aw_ready = mst_req_i.w_valid && !wr_pend_q;
      mst_resp_o.w_ready  = mst_req_i.aw_valid && !wr_pend_q;
    end
    if (wr_pend_q) begin
      mst_resp_o.b_valid = 1'b1;
      mst_resp_o.b_resp  = periph_link_pkg::RESP_SLVERR;
    end
    if (!ar_hit) begin
      mst_resp_o.ar_ready = !rd_pend_q;
    end
    if (rd_pend_q) begin
      mst_resp_o.r_valid = 1'b1;
      mst_resp_o.r_data  = '0;
      mst_resp_o.r_resp  = periph_link_pkg::RESP_SLVERR;
    end
  end

  //////////////////////////////////////////////////
  // Error responder pending flags
  //////////////////////////////////////////////////

  always_ff @(posedge periphl_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_pend_q <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      if (wr_pend_q) begin
        wr_pend_q <= !mst_req_i.b_ready;
      end else if (mst_req_i.aw_valid && mst_req_i.w_valid && !aw_hit) begin
        wr_pend_q <= 1'b1;
      end
      if (rd_pend_q) begin
        rd_pend_q <= !mst_req_i.r_ready;
      end else if (mst_req_i.ar_valid && !ar_hit) begin
        rd_pend_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs #(
  parameter int unsigned CLKS_PER_BIT = 868
) (
  input  logic                        periphl_clk_i,
  input  logic                        rst_n_i,
  input  periph_link_pkg::axil_req_t  axil_req_i,
  output periph_link_pkg::axil_resp_t axil_resp_o,
  output logic                        tx_start_o,
  output logic [7:0]                  tx_byte_o,
  input  logic                        tx_busy_i,
  input  logic                        rx_strobe_i,
  input  logic [7:0]                  rx_byte_i,
  output logic [15:0]                 baud_div_o
);

  periph_link_pkg::uart_reg_e wr_reg;
  periph_link_pkg::uart_reg_e rd_reg;

  logic                                wr_ok;
  logic                                rd_ok;
  logic                                wr_fire;
  logic                                rd_fire;
  logic                                bvalid_q;
  logic                                rvalid_q;
  logic [periph_link_pkg::DATA_W-1:0] rd_word;
  logic [periph_link_pkg::DATA_W-1:0] rdata_q;
  logic [15:0]                         baud_div_q;
  logic                                tx_start_q;
  logic [7:0]                          tx_byte_q;
  logic [7:0]                          rx_byte_q;
  logic                                rx_valid_q;

  // Offsets beyond the four registers fall to the default arm
  assign wr_reg = periph_link_pkg::uart_reg_e'(axil_req_i.aw_addr[3:0]);
  assign rd_reg = periph_link_pkg::uart_reg_e'(axil_req_i.ar_addr[3:0]);
  assign wr_ok  = (axil_req_i.aw_addr[11:4] == '0);
  assign rd_ok  = (axil_req_i.ar_addr[11:4] == '0);

  assign wr_fire = axil_req_i.aw_valid && axil_req_i.w_valid && !bvalid_q;
  assign rd_fire = axil_req_i.ar_valid && !rvalid_q;

  always_comb begin
    rd_word = '0;
    if (rd_ok) begin
      case (rd_reg)
        periph_link_pkg::REG_RXDATA:  rd_word[7:0] = rx_byte_q;
        periph_link_pkg::REG_STATUS:  rd_word[1:0] = {rx_valid_q, tx_busy_i};
        periph_link_pkg::REG_BAUDDIV: rd_word[15:0] = baud_div_q;
        default:                      rd_word = '0;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Handshake and register state
  //////////////////////////////////////////////////

  always_ff @(posedge periphl_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q   <= 1'b0;
      rvalid_q   <= 1'b0;
      baud_div_q <= 16'(CLKS_PER_BIT);
      tx_start_q <= 1'b0;
      rx_valid_q <= 1'b0;
    end else begin
      tx_start_q <= 1'b0;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.b_ready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.r_ready) begin
        rvalid_q <= 1'b0;
      end
      if (wr_fire && wr_ok && wr_reg == periph_link_pkg::REG_BAUDDIV) begin
        if (axil_req_i.w_strb[0]) baud_div_q[7:0] <= axil_req_i.w_data[7:0];
        if (axil_req_i.w_strb[1]) baud_div_q[15:8] <= axil_req_i.w_data[15:8];
      end
      // Busy transmitter drops the byte silently
      if (wr_fire && wr_ok && wr_reg == periph_link_pkg::REG_TXDATA &&
          axil_req_i.w_strb[0] && !tx_busy_i) begin
        tx_start_q <= 1'b1;
      end
      if (rd_fire && rd_ok && rd_reg == periph_link_pkg::REG_RXDATA) begin
        rx_valid_q <= 1'b0;
      end
      if (rx_strobe_i) begin
        rx_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (rd_fire) rdata_q <= rd_word;
    if (wr_fire) tx_byte_q <= axil_req_i.w_data[7:0];
    if (rx_strobe_i) rx_byte_q <= rx_byte_i;
  end

  always_comb begin
    axil_resp_o          = '0;
    axil_resp_o.aw_ready = axil_req_i.w_valid && !bvalid_q;
    axil_resp_o.w_ready  = axil_req_i.aw_valid && !bvalid_q;
    axil_resp_o.b_valid  = bvalid_q;
    axil_resp_o.b_resp   = periph_link_pkg::RESP_OKAY;
    axil_resp_o.ar_ready = !rvalid_q;
    axil_resp_o.r_valid  = rvalid_q;
    axil_resp_o.r_data   = rdata_q;
    axil_resp_o.r_resp   = periph_link_pkg::RESP_OKAY;
  end

  assign tx_start_o = tx_start_q;
  assign tx_byte_o  = tx_byte_q;
  assign baud_div_o = baud_div_q;

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic        periphl_clk_i,
  input  logic        rst_n_i,
  input  logic        start_i,
  input  logic [7:0]  byte_i,
  input  logic [15:0] baud_div_i,
  output logic        busy_o,
  output logic        tx_o
);

  logic [9:0]  shift_q;
  logic [3:0]  bit_cnt_q;
  logic [15:0] cyc_cnt_q;
  logic        busy_q;
  logic        bit_end;

  assign bit_end = (cyc_cnt_q == baud_div_i - 16'd1);

  always_ff @(posedge periphl_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // All ones keeps the line idle high
      shift_q   <= '1;
      bit_cnt_q <= '0;
      cyc_cnt_q <= '0;
      busy_q    <= 1'b0;
    end else if (!busy_q) begin
      if (start_i) begin
        // Stop bit, data LSB first, start bit
        shift_q   <= {1'b1, byte_i, 1'b0};
        bit_cnt_q <= '0;
        cyc_cnt_q <= '0;
        busy_q    <= 1'b1;
      end
    end else if (bit_end) begin
      cyc_cnt_q <= '0;
      shift_q   <= {1'b1, shift_q[9:1]};
      if (bit_cnt_q == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end
    end else begin
      cyc_cnt_q <= cyc_cnt_q + 16'd1;
    end
  end

  assign busy_o = busy_q;
  assign tx_o   = shift_q[0];

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic        periphl_clk_i,
  input  logic        rst_n_i,
  input  logic        rx_i,
  input  logic [15:0] baud_div_i,
  output logic        strobe_o,
  output logic [7:0]  byte_o
);

  logic        rx_meta_q;
  logic        rx_sync_q;
  logic        rx_prev_q;
  logic        fall;
  logic        active_q;
  logic [3:0]  bit_cnt_q;
  logic [15:0] cyc_cnt_q;
  logic [15:0] limit;
  logic        strobe_q;
  logic [7:0]  shift_q;

  assign fall = rx_prev_q && !rx_sync_q;

  // First wait is half a bit, to land mid start bit
  assign limit = (bit_cnt_q == 4'd0) ? {1'b0, baud_div_i[15:1]} : baud_div_i;

  always_ff @(posedge periphl_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
      active_q  <= 1'b0;
      bit_cnt_q <= '0;
      cyc_cnt_q <= '0;
      strobe_q  <= 1'b0;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
      strobe_q  <= 1'b0;
      if (!active_q) begin
        if (fall) begin
          active_q  <= 1'b1;
          bit_cnt_q <= '0;
          cyc_cnt_q <= '0;
        end
      end else if (cyc_cnt_q == limit - 16'd1) begin
        cyc_cnt_q <= '0;
        bit_cnt_q <= bit_cnt_q + 4'd1;
        if (bit_cnt_q == 4'd0 && rx_sync_q) begin
          // Glitch, not a start bit
          active_q <= 1'b0;
        end
        if (bit_cnt_q == 4'd9) begin
          active_q <= 1'b0;
          strobe_q <= rx_sync_q;
        end
      end else begin
        cyc_cnt_q <= cyc_cnt_q + 16'd1;
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge periphl_clk_i) begin
    if (active_q && cyc_cnt_q == limit - 16'd1 &&
        bit_cnt_q >= 4'd1 && bit_cnt_q <= 4'd8) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign strobe_o = strobe_q;
  assign byte_o   = shift_q;

endmodule

`default_nettype wire

// File: periph_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_link_top #(
  parameter int unsigned CLKS_PER_BIT = 868
) (
  input  logic                       periphl_clk_i,
  input  logic                       rst_n_i,
  input  periph_link_pkg::apb_req_t  apb_req_i,
  output periph_link_pkg::apb_resp_t apb_resp_o,
  input  logic                       uart_rx_i,
  output logic                       uart_tx_o
);

  periph_link_pkg::axil_req_t  bridge_req;
  periph_link_pkg::axil_resp_t bridge_resp;
  periph_link_pkg::axil_req_t  uart_req;
  periph_link_pkg::axil_resp_t uart_resp;

  logic        tx_start;
  logic [7:0]  tx_byte;
  logic        tx_busy;
  logic        rx_strobe;
  logic [7:0]  rx_byte;
  logic [15:0] baud_div;

  //////////////////////////////////////////////////
  // Bus path
  //////////////////////////////////////////////////

  apb_to_axil u_apb_to_axil (
    .periphl_clk_i (periphl_clk_i),
    .rst_n_i       (rst_n_i),
    .apb_req_i     (apb_req_i),
    .apb_resp_o    (apb_resp_o),
    .axil_req_o    (bridge_req),
    .axil_resp_i   (bridge_resp)
  );

  periph_link_decode u_periph_link_decode (
    .periphl_clk_i (periphl_clk_i),
    .rst_n_i       (rst_n_i),
    .mst_req_i     (bridge_req),
    .mst_resp_o    (bridge_resp),
    .uart_req_o    (uart_req),
    .uart_resp_i   (uart_resp)
  );

  //////////////////////////////////////////////////
  // UART device
  //////////////////////////////////////////////////

  uart_regs #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_regs (
    .periphl_clk_i (periphl_clk_i),
    .rst_n_i       (rst_n_i),
    .axil_req_i    (uart_req),
    .axil_resp_o   (uart_resp),
    .tx_start_o    (tx_start),
    .tx_byte_o     (tx_byte),
    .tx_busy_i     (tx_busy),
    .rx_strobe_i   (rx_strobe),
    .rx_byte_i     (rx_byte),
    .baud_div_o    (baud_div)
  );

  uart_tx u_uart_tx (
    .periphl_clk_i (periphl_clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (tx_start),
    .byte_i        (tx_byte),
    .baud_div_i    (baud_div),
    .busy_o        (tx_busy),
    .tx_o          (uart_tx_o)
  );

  uart_rx u_uart_rx (
    .periphl_clk_i (periphl_clk_i),
    .rst_n_i       (rst_n_i),
    .rx_i          (uart_rx_i),
    .baud_div_i    (baud_div),
    .strobe_o      (rx_strobe),
    .byte_o        (rx_byte)
  );

endmodule

`default_nettype wire

// File: tb_periph_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_periph_link;

  localparam int unsigned CLKS_PER_BIT = 16;
  localparam int unsigned NUM_TESTS    = 28;
  localparam int unsigned NUM_BYTES    = 4;
  localparam int unsigned MAX_WAIT     = 2000;
  localparam int unsigned MAX_POLLS    = 100;
  localparam int unsigned WATCHDOG_NS  = NUM_TESTS * (12 * CLKS_PER_BIT * 10 + 1000);

  localparam logic [31:0] A_TXDATA  = periph_link_pkg::UART_BASE + 32'h0;
  localparam logic [31:0] A_RXDATA  = periph_link_pkg::UART_BASE + 32'h4;
  localparam logic [31:0] A_STATUS  = periph_link_pkg::UART_BASE + 32'h8;
  localparam logic [31:0] A_BAUDDIV = periph_link_pkg::UART_BASE + 32'hC;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_POLL
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [31:0] exp_rdata;
    logic        exp_err;
  } test_entry_t;

  logic                       clk;
  logic                       rst_n;
  periph_link_pkg::apb_req_t  apb_req;
  periph_link_pkg::apb_resp_t apb_resp;
  logic                       serial_line;

  test_entry_t tests [NUM_TESTS];
  logic [7:0]  tx_bytes [NUM_BYTES];
  int unsigned n_entries;
  int unsigned errors;
  int unsigned passed;
  int unsigned failed;
  integer      seed;

  // Transmitter looped straight back into the receiver
  periph_link_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_periph_link_top (
    .periphl_clk_i (clk),
    .rst_n_i       (rst_n),
    .apb_req_i     (apb_req),
    .apb_resp_o    (apb_resp),
    .uart_rx_i     (serial_line),
    .uart_tx_o     (serial_line)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  task automatic add_entry(input op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, input logic [31:0] exp_rdata,
                           input logic exp_err);
    test_entry_t e;
    e.op        = op;
    e.addr      = addr;
    e.wdata     = wdata;
    e.strb      = strb;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    tests[n_entries] = e;
    n_entries++;
  endtask

  task automatic build_table();
    int unsigned k;
    // Reset values
    add_entry(OP_READ, A_BAUDDIV, 32'h0, 4'h0, 32'(CLKS_PER_BIT), 1'b0);
    add_entry(OP_READ, A_STATUS, 32'h0, 4'h0, 32'h0, 1'b0);
    // Full and low-byte divisor writes before restoring the test rate
    add_entry(OP_WRITE, A_BAUDDIV, 32'hDEAD_0110, 4'hF, 32'h0, 1'b0);
    add_entry(OP_READ, A_BAUDDIV, 32'h0, 4'h0, 32'h0000_0110, 1'b0);
    add_entry(OP_WRITE, A_BAUDDIV, 32'hFFFF_FF20, 4'h1, 32'h0, 1'b0);
    add_entry(OP_READ, A_BAUDDIV, 32'h0, 4'h0, 32'h0000_0120, 1'b0);
    add_entry(OP_WRITE, A_BAUDDIV, 32'(CLKS_PER_BIT), 4'hF, 32'h0, 1'b0);
    add_entry(OP_READ, A_BAUDDIV, 32'h0, 4'h0, 32'(CLKS_PER_BIT), 1'b0);
    // Unmapped windows
    add_entry(OP_WRITE, 32'h0000_0000, 32'h5555_AAAA, 4'hF, 32'h0, 1'b1);
    add_entry(OP_READ, 32'h0000_0000, 32'h0, 4'h0, 32'h0, 1'b1);
    add_entry(OP_WRITE, 32'h0000_300C, 32'h0000_0003, 4'hF, 32'h0, 1'b1);
    add_entry(OP_READ, 32'h0000_3000, 32'h0, 4'h0, 32'h0, 1'b1);
    add_entry(OP_READ, A_BAUDDIV, 32'h0, 4'h0, 32'(CLKS_PER_BIT), 1'b0);
    // First loopback byte with busy seen mid frame
    add_entry(OP_WRITE, A_TXDATA, {24'h0, tx_bytes[0]}, 4'hF, 32'h0, 1'b0);
    add_entry(OP_READ, A_STATUS, 32'h0, 4'h0, 32'h1, 1'b0);
    add_entry(OP_POLL, A_STATUS, 32'h0, 4'h0, 32'h2, 1'b0);
    add_entry(OP_READ, A_RXDATA, 32'h0, 4'h0, {24'h0, tx_bytes[0]}, 1'b0);
    add_entry(OP_READ, A_STATUS, 32'h0, 4'h0, 32'h0, 1'b0);
    // Remaining bytes back to back
    for (k = 1; k < NUM_BYTES; k++) begin
      add_entry(OP_WRITE, A_TXDATA, {24'h0, tx_bytes[k]}, 4'hF, 32'h0, 1'b0);
      add_entry(OP_POLL, A_STATUS, 32'h0, 4'h0, 32'h2, 1'b0);
      add_entry(OP_READ, A_RXDATA, 32'h0, 4'h0, {24'h0, tx_bytes[k]}, 1'b0);
    end
    add_entry(OP_READ, A_STATUS, 32'h0, 4'h0, 32'h0, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // APB driver and checks
  //////////////////////////////////////////////////

  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              output logic [31:0] rdata, output logic err);
    periph_link_pkg::apb_req_t req;
    int unsigned               waited;
    req        = '0;
    req.psel   = 1'b1;
    req.pwrite = write;
    req.paddr  = addr;
    req.pwdata = wdata;
    req.pstrb  = strb;
    rdata      = '0;
    err        = 1'b0;
    waited     = 0;
    // Setup phase
    @(posedge clk);
    apb_req <= req;
    // Access phase
    req.penable = 1'b1;
    @(posedge clk);
    apb_req <= req;
    @(negedge clk);
    while (!apb_resp.pready && waited < MAX_WAIT) begin
      @(negedge clk);
      waited++;
    end
    assert (apb_resp.pready) else begin
      $display("APB transfer to 0x%08h got no pready within %0d cycles", addr, MAX_WAIT);
      errors++;
    end
    if (apb_resp.pready) begin
      rdata = apb_resp.prdata;
      err   = apb_resp.pslverr;
    end
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp, input int unsigned idx);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: test %0d %s is 0x%08h, expected 0x%08h",
               $time, idx, what, got, exp);
      errors++;
    end
  endtask

  function automatic string op_label(input op_e op);
    case (op)
      OP_WRITE: return "write";
      OP_READ:  return "read";
      default:  return "poll";
    endcase
  endfunction

  task automatic run_entry(input int unsigned idx);
    test_entry_t e;
    logic [31:0] rdata;
    logic        err;
    logic        done;
    int unsigned polls;
    int unsigned errs_before;
    e           = tests[idx];
    errs_before = errors;
    case (e.op)
      OP_WRITE: begin
        apb_transfer(1'b1, e.addr, e.wdata, e.strb, rdata, err);
        check_value("pslverr", {31'h0, err}, {31'h0, e.exp_err}, idx);
      end
      OP_READ: begin
        apb_transfer(1'b0, e.addr, 32'h0, 4'h0, rdata, err);
        check_value("pslverr", {31'h0, err}, {31'h0, e.exp_err}, idx);
        check_value("prdata", rdata, e.exp_rdata, idx);
      end
      default: begin
        polls = 0;
        done  = 1'b0;
        while (!done && polls < MAX_POLLS) begin
          apb_transfer(1'b0, e.addr, 32'h0, 4'h0, rdata, err);
          check_value("pslverr", {31'h0, err}, {31'h0, e.exp_err}, idx);
          polls++;
          done = (rdata === e.exp_rdata);
        end
        assert (done) else begin
          $display("MISMATCH at %0t: test %0d after %0d polls is 0x%08h, expected 0x%08h",
                   $time, idx, polls, rdata, e.exp_rdata);
          errors++;
        end
      end
    endcase
    if (errors == errs_before) begin
      passed++;
      $display("test %0d %s 0x%08h ok", idx, op_label(e.op), e.addr);
    end else begin
      failed++;
      $display("test %0d %s 0x%08h failed", idx, op_label(e.op), e.addr);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    int unsigned i;
    rst_n     = 1'b0;
    apb_req   = '0;
    seed      = 32'hfaeeadc3;
    n_entries = 0;
    errors    = 0;
    passed    = 0;
    failed    = 0;
    for (i = 0; i < NUM_BYTES; i++) begin
      tx_bytes[i] = 8'($random(seed));
    end
    build_table();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    // Serial line idles high out of reset
    @(negedge clk);
    assert (serial_line === 1'b1) else begin
      $display("MISMATCH at %0t: serial line is %b after reset, expected 1",
               $time, serial_line);
      errors++;
    end
    for (i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d", n_entries, passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
periph_link_pkg.sv
apb_to_axil.sv
periph_link_decode.sv
uart_regs.sv
uart_tx.sv
uart_rx.sv
periph_link_top.sv
tb_periph_link.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_periph_link -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
  exit 0
else
  exit 1
fi
